// File: hdl/axi_sram_pkg.sv
// AXI SRAM package: bus widths, vector typedefs, burst and response codes, channel structs

package axi_sram_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // --------------------
  // Field types
  // --------------------
  typedef logic [3:0]            axi_id_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [7:0]            axi_len_t;
  typedef logic [2:0]            axi_size_t;
  typedef logic [1:0]            axi_burst_t;
  typedef logic [1:0]            axi_resp_t;

  // Burst types with value 3 reserved
  localparam axi_burst_t BURST_FIXED = 2'd0;
  localparam axi_burst_t BURST_INCR  = 2'd1;
  localparam axi_burst_t BURST_WRAP  = 2'd2;

  // Only the two codes this slave returns
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // --------------------
  // Channel payloads
  // --------------------

  // Shared by AW and AR
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ax_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

endpackage

// File: hdl/axi_burst_addr.sv
// AXI burst address generator: FIXED/INCR/WRAP beat address, last-beat and range flags
`timescale 1ns/1ps

module axi_burst_addr #(
  parameter int MEM_DEPTH = 1024
) (
  input  logic                    i_aclk,
  input  logic                    i_reset,
  input  logic                    i_load,
  input  axi_sram_pkg::axi_ax_t   i_ax,
  input  logic                    i_step,
  output axi_sram_pkg::axi_addr_t o_addr,
  output logic                    o_last,
  output logic                    o_in_range
);

  localparam int WORD_AW = $clog2(MEM_DEPTH);

  axi_sram_pkg::axi_addr_t  addr_q;
  axi_sram_pkg::axi_addr_t  wrap_mask_q;
  axi_sram_pkg::axi_size_t  size_q;
  axi_sram_pkg::axi_burst_t burst_q;
  axi_sram_pkg::axi_len_t   len_q;
  axi_sram_pkg::axi_len_t   cnt_q;

  axi_sram_pkg::axi_addr_t  incr;
  axi_sram_pkg::axi_addr_t  aligned;
  axi_sram_pkg::axi_addr_t  next_addr;

  // Bytes per beat and the size-aligned base
  assign incr    = axi_sram_pkg::axi_addr_t'(1) << size_q;
  assign aligned = addr_q & ~(incr - axi_sram_pkg::axi_addr_t'(1));

  always_comb begin
    case (burst_q)
      axi_sram_pkg::BURST_FIXED: next_addr = addr_q;
      axi_sram_pkg::BURST_INCR:  next_addr = aligned + incr;
      // Low bits roll over inside the aligned window
      axi_sram_pkg::BURST_WRAP:
        next_addr = (addr_q & ~wrap_mask_q) | ((addr_q + incr) & wrap_mask_q);
      default:                   next_addr = aligned + incr;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      cnt_q   <= '0;
      burst_q <= axi_sram_pkg::BURST_INCR;
    end else if (i_load) begin
      cnt_q   <= '0;
      burst_q <= i_ax.burst;
    end else if (i_step) begin
      cnt_q   <= cnt_q + 8'd1;
    end
  end

  // Address and burst shape
  always_ff @(posedge i_aclk) begin
    if (i_load) begin
      addr_q      <= i_ax.addr;
      size_q      <= i_ax.size;
      len_q       <= i_ax.len;
      // Window size is beats times bytes per beat
      wrap_mask_q <= ((axi_sram_pkg::axi_addr_t'(i_ax.len) + axi_sram_pkg::axi_addr_t'(1))
                      << i_ax.size) - axi_sram_pkg::axi_addr_t'(1);
    end else if (i_step) begin
      addr_q      <= next_addr;
    end
  end

  assign o_addr = addr_q;
  assign o_last = (cnt_q == len_q);

  // Upper bits clear and word index below depth
  assign o_in_range = ~|addr_q[axi_sram_pkg::AXI_ADDR_W-1:WORD_AW+3] &&
                      ({1'b0, addr_q[WORD_AW+2:3]} < (WORD_AW+1)'(MEM_DEPTH));

endmodule

// File: hdl/sram_array.sv
// Byte-lane SRAM array with one strobed write port and one registered read port
`timescale 1ns/1ps

module sram_array #(
  parameter int MEM_DEPTH = 1024
) (
  input  logic                    i_aclk,
  input  logic                    i_wen,
  input  logic                    i_wr_ok,
  input  axi_sram_pkg::axi_addr_t i_waddr,
  input  axi_sram_pkg::axi_strb_t i_wstrb,
  input  axi_sram_pkg::axi_data_t i_wdata,
  input  logic                    i_ren,
  input  axi_sram_pkg::axi_addr_t i_raddr,
  input  logic                    i_rd_ok,
  output axi_sram_pkg::axi_data_t o_rdata
);

  localparam int WORD_AW = $clog2(MEM_DEPTH);

  axi_sram_pkg::axi_data_t mem [MEM_DEPTH];

  logic [WORD_AW-1:0] waddr;
  logic [WORD_AW-1:0] raddr;

  // Byte address to word index
  assign waddr = i_waddr[WORD_AW+2:3];
  assign raddr = i_raddr[WORD_AW+2:3];

  // Write port
  always_ff @(posedge i_aclk) begin
    if (i_wen && i_wr_ok) begin
      for (int b = 0; b < axi_sram_pkg::AXI_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read port returns zero for out-of-range beats
  always_ff @(posedge i_aclk) begin
    if (i_ren) begin
      o_rdata <= i_rd_ok ? mem[raddr] : '0;
    end
  end

endmodule

// File: hdl/axi_resp_gen.sv
// AXI response generator: ID capture, sticky write error, per-beat read response
`timescale 1ns/1ps

module axi_resp_gen (
  input  logic                    i_aclk,
  input  logic                    i_reset,

  input  logic                    i_wr_start,
  input  axi_sram_pkg::axi_id_t   i_awid,
  input  logic                    i_wr_beat,
  input  logic                    i_wr_ok,

  input  logic                    i_rd_start,
  input  axi_sram_pkg::axi_id_t   i_arid,
  input  logic                    i_rd_issue,
  input  logic                    i_rd_ok,

  output axi_sram_pkg::axi_b_t    o_b,
  output axi_sram_pkg::axi_id_t   o_rid,
  output axi_sram_pkg::axi_resp_t o_rresp
);

  axi_sram_pkg::axi_id_t   bid_q;
  axi_sram_pkg::axi_id_t   rid_q;
  axi_sram_pkg::axi_resp_t rresp_q;
  logic                    werr_q;

  // IDs held for the whole burst
  always_ff @(posedge i_aclk) begin
    if (i_wr_start) bid_q <= i_awid;
    if (i_rd_start) rid_q <= i_arid;
  end

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      werr_q  <= 1'b0;
      rresp_q <= axi_sram_pkg::RESP_OKAY;
    end else begin
      // One bad beat marks the whole write burst
      if (i_wr_start) begin
        werr_q <= 1'b0;
      end else if (i_wr_beat && !i_wr_ok) begin
        werr_q <= 1'b1;
      end
      // Same cycle as the array read data
      if (i_rd_issue) begin
        rresp_q <= i_rd_ok ? axi_sram_pkg::RESP_OKAY : axi_sram_pkg::RESP_SLVERR;
      end
    end
  end

  assign o_b.id   = bid_q;
  assign o_b.resp = werr_q ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;
  assign o_rid    = rid_q;
  assign o_rresp  = rresp_q;

endmodule

// File: hdl/axi_sram_ctrl.sv
// AXI SRAM control: write and read FSMs, channel handshakes, beat sequencing strobes
`timescale 1ns/1ps

module axi_sram_ctrl (
  input  logic                    i_aclk,
  input  logic                    i_reset,

  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  axi_sram_pkg::axi_w_t    i_w,
  output logic                    o_bvalid,
  input  logic                    i_bready,
  input  logic                    i_arvalid,
  output logic                    o_arready,
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic                    o_rlast,

  // Burst address generators
  output logic                    o_wr_load,
  output logic                    o_wr_step,
  input  logic                    i_wr_last,
  output logic                    o_rd_load,
  output logic                    o_rd_step,
  input  logic                    i_rd_last,

  // Memory array
  output logic                    o_mem_wen,
  output axi_sram_pkg::axi_strb_t o_mem_wstrb,
  output axi_sram_pkg::axi_data_t o_mem_wdata,
  output logic                    o_mem_ren
);

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA
  } rd_state_e;

  wr_state_e wr_state;
  rd_state_e rd_state;
  logic      rlast_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // Readies come from state only
  assign o_awready = (wr_state == W_IDLE);
  assign o_wready  = (wr_state == W_DATA);
  assign o_bvalid  = (wr_state == W_RESP);
  assign o_arready = (rd_state == R_IDLE);
  assign o_rvalid  = (rd_state == R_DATA);

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // --------------------
  // Write path
  // --------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      wr_state <= W_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: if (aw_fire) wr_state <= W_DATA;
        // End of burst from own beat count and not from W last
        W_DATA: if (w_fire && i_wr_last) wr_state <= W_RESP;
        W_RESP: if (b_fire) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  assign o_wr_load   = aw_fire;
  assign o_wr_step   = w_fire;
  assign o_mem_wen   = w_fire;
  assign o_mem_wstrb = i_w.strb;
  assign o_mem_wdata = i_w.data;

  // --------------------
  // Read path
  // --------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: if (ar_fire) rd_state <= R_ADDR;
        R_ADDR: rd_state <= R_DATA;
        R_DATA: begin
          if (r_fire) begin
            rd_state <= rlast_q ? R_IDLE : R_ADDR;
          end
        end
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // Last flag sampled with the array read
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      rlast_q <= 1'b0;
    end else if (o_mem_ren) begin
      rlast_q <= i_rd_last;
    end
  end

  assign o_rd_load = ar_fire;
  assign o_rd_step = r_fire & ~rlast_q;
  assign o_mem_ren = (rd_state == R_ADDR);
  assign o_rlast   = rlast_q;

endmodule

// File: hdl/axi_sram_top.sv
// AXI4 SRAM slave top: control, two burst address generators, array, response generator
`timescale 1ns/1ps

module axi_sram_top #(
  parameter int MEM_DEPTH = 1024
) (
  input  logic                  i_aclk,
  input  logic                  i_reset,

  input  axi_sram_pkg::axi_ax_t i_aw,
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  axi_sram_pkg::axi_w_t  i_w,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  output axi_sram_pkg::axi_b_t  o_b,
  output logic                  o_bvalid,
  input  logic                  i_bready,

  input  axi_sram_pkg::axi_ax_t i_ar,
  input  logic                  i_arvalid,
  output logic                  o_arready,
  output axi_sram_pkg::axi_r_t  o_r,
  output logic                  o_rvalid,
  input  logic                  i_rready
);

  logic wr_load, wr_step, wr_last, wr_in_range;
  logic rd_load, rd_step, rd_last, rd_in_range;
  logic mem_wen, mem_ren, rlast;

  axi_sram_pkg::axi_addr_t wr_addr;
  axi_sram_pkg::axi_addr_t rd_addr;
  axi_sram_pkg::axi_strb_t mem_wstrb;
  axi_sram_pkg::axi_data_t mem_wdata;
  axi_sram_pkg::axi_data_t mem_rdata;
  axi_sram_pkg::axi_id_t   rd_id;
  axi_sram_pkg::axi_resp_t rd_resp;

  axi_sram_ctrl u_ctrl (
    .i_aclk, .i_reset,
    .i_awvalid, .o_awready, .i_wvalid, .o_wready, .i_w,
    .o_bvalid, .i_bready, .i_arvalid, .o_arready, .o_rvalid, .i_rready,
    .o_rlast(rlast),
    .o_wr_load(wr_load), .o_wr_step(wr_step), .i_wr_last(wr_last),
    .o_rd_load(rd_load), .o_rd_step(rd_step), .i_rd_last(rd_last),
    .o_mem_wen(mem_wen), .o_mem_wstrb(mem_wstrb), .o_mem_wdata(mem_wdata),
    .o_mem_ren(mem_ren)
  );

  axi_burst_addr #(.MEM_DEPTH(MEM_DEPTH)) u_wr_addr (
    .i_aclk, .i_reset, .i_load(wr_load), .i_ax(i_aw), .i_step(wr_step),
    .o_addr(wr_addr), .o_last(wr_last), .o_in_range(wr_in_range)
  );

  axi_burst_addr #(.MEM_DEPTH(MEM_DEPTH)) u_rd_addr (
    .i_aclk, .i_reset, .i_load(rd_load), .i_ax(i_ar), .i_step(rd_step),
    .o_addr(rd_addr), .o_last(rd_last), .o_in_range(rd_in_range)
  );

  sram_array #(.MEM_DEPTH(MEM_DEPTH)) u_array (
    .i_aclk, .i_wen(mem_wen), .i_wr_ok(wr_in_range), .i_waddr(wr_addr),
    .i_wstrb(mem_wstrb), .i_wdata(mem_wdata),
    .i_ren(mem_ren), .i_raddr(rd_addr), .i_rd_ok(rd_in_range), .o_rdata(mem_rdata)
  );

  axi_resp_gen u_resp (
    .i_aclk, .i_reset,
    .i_wr_start(wr_load), .i_awid(i_aw.id), .i_wr_beat(mem_wen), .i_wr_ok(wr_in_range),
    .i_rd_start(rd_load), .i_arid(i_ar.id), .i_rd_issue(mem_ren), .i_rd_ok(rd_in_range),
    .o_b, .o_rid(rd_id), .o_rresp(rd_resp)
  );

  // Read beat assembled from the registered pieces
  assign o_r = '{id: rd_id, data: mem_rdata, resp: rd_resp, last: rlast};

endmodule

// File: tests/axi_sram_asserts.sv
// Concurrent assertions on the B, R and W handshake rules of the AXI SRAM slave
`timescale 1ns/1ps

module axi_sram_asserts (
  input logic                 i_aclk,
  input logic                 i_reset,
  input logic                 i_awvalid,
  input logic                 i_awready,
  input logic                 i_wvalid,
  input logic                 i_wready,
  input logic                 i_wr_last,
  input logic                 i_bvalid,
  input logic                 i_bready,
  input axi_sram_pkg::axi_b_t i_b,
  input logic                 i_rvalid,
  input logic                 i_rready,
  input axi_sram_pkg::axi_r_t i_r
);

  int   fail_count = 0;
  logic wr_open;

  // Open from the AW transfer to the last W transfer
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      wr_open <= 1'b0;
    end else if (i_awvalid && i_awready) begin
      wr_open <= 1'b1;
    end else if (i_wvalid && i_wready && i_wr_last) begin
      wr_open <= 1'b0;
    end
  end

  // Response channels hold under back-pressure
  assert property (@(posedge i_aclk) disable iff (i_reset)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_b))
    else begin
      $error("B valid or payload changed before the transfer");
      fail_count++;
    end

  assert property (@(posedge i_aclk) disable iff (i_reset)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_r))
    else begin
      $error("R valid or payload changed before the transfer");
      fail_count++;
    end

  // B follows the last W beat by one cycle
  assert property (@(posedge i_aclk) disable iff (i_reset)
    i_wvalid && i_wready && i_wr_last |=> i_bvalid)
    else begin
      $error("bvalid missing one cycle after the last W transfer");
      fail_count++;
    end

  assert property (@(posedge i_aclk) disable iff (i_reset)
    $rose(i_bvalid) |-> $past(i_wvalid && i_wready && i_wr_last))
    else begin
      $error("bvalid rose without a last W transfer in the cycle before");
      fail_count++;
    end

  assert property (@(posedge i_aclk) disable iff (i_reset)
    i_wready |-> wr_open)
    else begin
      $error("wready high outside a write burst");
      fail_count++;
    end

endmodule

bind axi_sram_top axi_sram_asserts u_asserts (
  .i_aclk(i_aclk), .i_reset(i_reset), .i_awvalid(i_awvalid), .i_awready(o_awready),
  .i_wvalid(i_wvalid), .i_wready(o_wready), .i_wr_last(wr_last),
  .i_bvalid(o_bvalid), .i_bready(i_bready), .i_b(o_b),
  .i_rvalid(o_rvalid), .i_rready(i_rready), .i_r(o_r)
);

// File: tests/tb_axi_sram.sv
// Testbench for the AXI4 SRAM slave: clock, reset, AXI driver tasks, reference memory, checks
`timescale 1ns/1ps

module tb_axi_sram;

  localparam int MEM_DEPTH      = 1024;
  localparam int MEM_BYTES      = MEM_DEPTH * 8;
  // Limit far above the length of all tests
  localparam int TIMEOUT_CYCLES = 20000;

  logic                  i_aclk;
  logic                  i_reset;
  axi_sram_pkg::axi_ax_t i_aw;
  logic                  i_awvalid;
  logic                  o_awready;
  axi_sram_pkg::axi_w_t  i_w;
  logic                  i_wvalid;
  logic                  o_wready;
  axi_sram_pkg::axi_b_t  o_b;
  logic                  o_bvalid;
  logic                  i_bready;
  axi_sram_pkg::axi_ax_t i_ar;
  logic                  i_arvalid;
  logic                  o_arready;
  axi_sram_pkg::axi_r_t  o_r;
  logic                  o_rvalid;
  logic                  i_rready;

  // Byte-addressed model of the array
  logic [7:0] ref_mem [MEM_BYTES];
  int         errors = 0;
  int         cycles = 0;

  axi_sram_top #(.MEM_DEPTH(MEM_DEPTH)) UUT (.*);

  initial begin
    i_aclk = 1'b0;
    forever #4 i_aclk = ~i_aclk;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge i_aclk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic next_edge();
    @(posedge i_aclk);
    #1;
  endtask

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic axi_sram_pkg::axi_ax_t make_ax(input int id, input int unsigned addr,
                                                    input int len, input int size,
                                                    input axi_sram_pkg::axi_burst_t burst);
    return '{id: 4'(id), addr: addr, len: 8'(len), size: 3'(size), burst: burst};
  endfunction

  function automatic bit in_mem(input axi_sram_pkg::axi_addr_t addr);
    return addr < MEM_BYTES;
  endfunction

  // Next beat address by the AXI burst rules
  function automatic axi_sram_pkg::axi_addr_t beat_addr_next(input axi_sram_pkg::axi_addr_t addr,
                                                             input axi_sram_pkg::axi_ax_t ax);
    int unsigned bytes;
    int unsigned window;
    int unsigned base;
    int unsigned nxt;
    bytes  = 1 << ax.size;
    window = bytes * (ax.len + 1);
    base   = (addr / window) * window;
    nxt    = (addr / bytes) * bytes + bytes;
    if (ax.burst == axi_sram_pkg::BURST_FIXED) return addr;
    if (ax.burst == axi_sram_pkg::BURST_WRAP && nxt >= base + window) return base;
    return nxt;
  endfunction

  // Lanes a beat may drive from its address to the end of its size block
  function automatic axi_sram_pkg::axi_strb_t lane_mask(input axi_sram_pkg::axi_addr_t addr,
                                                        input axi_sram_pkg::axi_size_t size);
    int unsigned lo;
    int unsigned hi;
    lo = addr % 8;
    hi = (lo / (1 << size)) * (1 << size) + (1 << size);
    return 8'(((1 << hi) - 1) & ~((1 << lo) - 1));
  endfunction

  function automatic axi_sram_pkg::axi_data_t ref_word(input axi_sram_pkg::axi_addr_t addr);
    axi_sram_pkg::axi_data_t d;
    for (int b = 0; b < 8; b++) begin
      d[b*8 +: 8] = ref_mem[(addr & ~32'h7) + b];
    end
    return d;
  endfunction

  // --------------------
  // AXI drivers
  // --------------------
  task automatic axi_write_burst(input axi_sram_pkg::axi_ax_t ax, input bit rand_strb,
                                 input bit stall);
    axi_sram_pkg::axi_addr_t addr;
    axi_sram_pkg::axi_resp_t exp_resp;
    addr      = ax.addr;
    exp_resp  = axi_sram_pkg::RESP_OKAY;
    i_aw      = ax;
    i_awvalid = 1'b1;
    do @(negedge i_aclk); while (!o_awready);
    next_edge();
    i_awvalid = 1'b0;
    for (int n = 0; n <= ax.len; n++) begin
      if (stall) repeat ($urandom_range(0, 2)) next_edge();
      i_w.data = {$urandom, $urandom};
      i_w.strb = lane_mask(addr, ax.size) & (rand_strb ? 8'($urandom) : 8'hff);
      i_w.last = (n == ax.len);
      i_wvalid = 1'b1;
      do @(negedge i_aclk); while (!o_wready);
      if (in_mem(addr)) begin
        for (int b = 0; b < 8; b++) begin
          if (i_w.strb[b]) ref_mem[(addr & ~32'h7) + b] = i_w.data[b*8 +: 8];
        end
      end else begin
        exp_resp = axi_sram_pkg::RESP_SLVERR;
      end
      next_edge();
      i_wvalid = 1'b0;
      addr     = beat_addr_next(addr, ax);
    end
    forever begin
      i_bready = stall ? ($urandom_range(0, 2) == 0) : 1'b1;
      @(negedge i_aclk);
      if (o_bvalid && i_bready) break;
      next_edge();
    end
    check_val(o_b.id, ax.id, "B id");
    check_val(o_b.resp, exp_resp, "B resp");
    next_edge();
    i_bready = 1'b0;
  endtask

  task automatic axi_read_burst(input axi_sram_pkg::axi_ax_t ax, input bit stall);
    axi_sram_pkg::axi_addr_t addr;
    addr      = ax.addr;
    i_ar      = ax;
    i_arvalid = 1'b1;
    do @(negedge i_aclk); while (!o_arready);
    next_edge();
    i_arvalid = 1'b0;
    for (int n = 0; n <= ax.len; n++) begin
      forever begin
        i_rready = stall ? ($urandom_range(0, 2) != 0) : 1'b1;
        @(negedge i_aclk);
        if (o_rvalid && i_rready) break;
        next_edge();
      end
      check_val(o_r.id, ax.id, "R id");
      check_val(o_r.data, in_mem(addr) ? ref_word(addr) : '0, $sformatf("R data at %h", addr));
      check_val(o_r.resp, in_mem(addr) ? axi_sram_pkg::RESP_OKAY : axi_sram_pkg::RESP_SLVERR,
                $sformatf("R resp at %h", addr));
      check_val(o_r.last, n == ax.len, "R last");
      next_edge();
      i_rready = 1'b0;
      addr     = beat_addr_next(addr, ax);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_and_single_beats();
    check_val(o_awready, 1'b1, "awready after reset");
    check_val(o_arready, 1'b1, "arready after reset");
    check_val(o_wready, 1'b0, "wready after reset");
    check_val(o_bvalid, 1'b0, "bvalid after reset");
    check_val(o_rvalid, 1'b0, "rvalid after reset");
    for (int i = 0; i < 4; i++) begin
      axi_write_burst(make_ax(i + 1, i * 8, 0, 3, axi_sram_pkg::BURST_INCR), 0, 0);
      axi_read_burst(make_ax(15 - i, i * 8, 0, 3, axi_sram_pkg::BURST_INCR), 0);
    end
  endtask

  task automatic partial_strobes();
    axi_write_burst(make_ax(2, 'h200, 0, 3, axi_sram_pkg::BURST_INCR), 0, 0);
    repeat (6) begin
      axi_write_burst(make_ax(3, 'h200, 0, 3, axi_sram_pkg::BURST_INCR), 1, 0);
      axi_read_burst(make_ax(4, 'h200, 0, 3, axi_sram_pkg::BURST_INCR), 0);
    end
  endtask

  task automatic incr_and_fixed_bursts();
    axi_write_burst(make_ax(5, 'h400, 7, 3, axi_sram_pkg::BURST_INCR), 0, 0);
    axi_read_burst(make_ax(6, 'h400, 7, 3, axi_sram_pkg::BURST_INCR), 0);
    axi_write_burst(make_ax(7, 'h500, 15, 3, axi_sram_pkg::BURST_INCR), 0, 0);
    axi_read_burst(make_ax(8, 'h500, 15, 3, axi_sram_pkg::BURST_INCR), 0);
    // Narrow beats with two per word
    axi_write_burst(make_ax(9, 'h600, 9, 2, axi_sram_pkg::BURST_INCR), 0, 0);
    axi_read_burst(make_ax(10, 'h600, 4, 3, axi_sram_pkg::BURST_INCR), 0);
    axi_write_burst(make_ax(11, 'h700, 3, 3, axi_sram_pkg::BURST_FIXED), 0, 0);
    axi_read_burst(make_ax(12, 'h700, 3, 3, axi_sram_pkg::BURST_FIXED), 0);
  endtask

  task automatic wrap_bursts();
    // Windows 0x800-0x81f and 0x900-0x93f
    axi_write_burst(make_ax(1, 'h810, 3, 3, axi_sram_pkg::BURST_WRAP), 0, 0);
    axi_read_burst(make_ax(2, 'h810, 3, 3, axi_sram_pkg::BURST_WRAP), 0);
    axi_read_burst(make_ax(3, 'h800, 3, 3, axi_sram_pkg::BURST_INCR), 0);
    axi_write_burst(make_ax(4, 'h928, 7, 3, axi_sram_pkg::BURST_WRAP), 0, 0);
    axi_read_burst(make_ax(5, 'h918, 7, 3, axi_sram_pkg::BURST_WRAP), 0);
  endtask

  task automatic backpressure_and_overlap();
    axi_write_burst(make_ax(6, 'ha00, 15, 3, axi_sram_pkg::BURST_INCR), 0, 1);
    axi_read_burst(make_ax(7, 'ha00, 15, 3, axi_sram_pkg::BURST_INCR), 1);
    fork
      axi_write_burst(make_ax(8, 'hc00, 7, 3, axi_sram_pkg::BURST_INCR), 0, 1);
      axi_read_burst(make_ax(9, 'h400, 7, 3, axi_sram_pkg::BURST_INCR), 1);
    join
    axi_read_burst(make_ax(10, 'hc00, 7, 3, axi_sram_pkg::BURST_INCR), 1);
  endtask

  task automatic out_of_range_burst();
    axi_write_burst(make_ax(11, MEM_BYTES - 64, 7, 3, axi_sram_pkg::BURST_INCR), 0, 0);
    // Last four beats fall past the end
    axi_write_burst(make_ax(12, MEM_BYTES - 32, 7, 3, axi_sram_pkg::BURST_INCR), 0, 0);
    axi_read_burst(make_ax(13, MEM_BYTES - 64, 11, 3, axi_sram_pkg::BURST_INCR), 0);
    // Words that an out-of-range index would alias to
    axi_read_burst(make_ax(14, 0, 3, 3, axi_sram_pkg::BURST_INCR), 0);
  endtask

  initial begin
    void'($urandom(32'h3b00_8163));
    i_reset   = 1'b1;
    i_aw      = '0;
    i_awvalid = 1'b0;
    i_w       = '0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_ar      = '0;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    repeat (10) @(posedge i_aclk);
    #1;
    i_reset = 1'b0;
    next_edge();
    reset_and_single_beats();
    partial_strobes();
    incr_and_fixed_bursts();
    wrap_bursts();
    backpressure_and_overlap();
    out_of_range_burst();
    $display("Run complete after %0d cycles with %0d check errors and %0d assertion failures",
             cycles, errors, UUT.u_asserts.fail_count);
    if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
hdl/axi_sram_pkg.sv
hdl/axi_burst_addr.sv
hdl/sram_array.sv
hdl/axi_resp_gen.sv
hdl/axi_sram_ctrl.sv
hdl/axi_sram_top.sv
tests/axi_sram_asserts.sv
tests/tb_axi_sram.sv
